//--- all.f
dcache_ctrl_pkg.sv
port_hit_decode.sv
pmem_arbiter.sv
miss_fsm.sv
ctrl_output_decode.sv
dcache_ctrl.sv
dcache_ctrl_assertions.sv
dcache_ctrl_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module dcache_ctrl_tb -f all.f -o sim_dcache
./obj_dir/sim_dcache +verilator+error+limit+1000 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
	exit 1
fi

//--- dcache_ctrl_tb.sv
`timescale 1ns/1ps

module dcache_ctrl_tb;
	import dcache_ctrl_pkg::*;

	// random traffic length
	localparam int NUM_CYCLES = 4000;
	// illegal requests only in the last stretch
	localparam int FAULT_PHASE = NUM_CYCLES - 80;
	// reset, traffic and a margin
	localparam int WATCHDOG_NS = (NUM_CYCLES + 4) * 20 + 2000;
	// outputs are compared this long after the falling edge
	localparam int SETTLE_NS = 5;

	logic clk;
	logic rst_n;
	port_vec_t d_mem_read;
	port_vec_t d_mem_write;
	port_vec_t d_mem_resp;
	port_vec_t data0_hit;
	port_vec_t data1_hit;
	port_vec_t rpb_hit;
	port_vec_t mshr_hit;
	port_vec_t mshr_reading_tag;
	logic dirty0_out;
	logic dirty1_out;
	logic lru_out;
	logic mshr_dirty;
	logic mshr_wait;
	logic rpb_wait;
	logic pmem_read;
	logic pmem_write;
	logic pmem_resp;
	way_vec_t load_data;
	way_vec_t load_dirty;
	way_vec_t load_valid;
	way_vec_t dirty_in;
	logic update_lru;
	logic lru_in;
	logic mshr_load_addr;
	logic mshr_load_word;
	logic mshr_load_line;
	logic inc_mshr_ptr;
	logic rpb_load_line;
	logic rpb_load_word;
	logic inc_rpb_ptr;
	logic fault;

	// reference model of the fsm and the arbiter
	ctrl_state_t m_state;
	logic m_rw;
	logic m_prev;
	// stimulus bookkeeping
	logic [15:0] lfsr;
	port_vec_t pend;
	port_vec_t answered;
	logic [3:0] mem_cnt;
	logic mem_seen;
	int errors;
	int checks;

	dcache_ctrl DUT (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// galois lfsr stepped once per bit
	function automatic logic lfsr_bit();
		logic lsb;
		lsb = lfsr[0];
		lfsr = lfsr >> 1;
		if (lsb)
			lfsr = lfsr ^ 16'hB400;
		return lsb;
	endfunction

	function automatic logic [3:0] rand_bits(input int n);
		logic [3:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[2:0], lfsr_bit()};
		return r;
	endfunction

	function automatic port_vec_t port_hits();
		return data0_hit | data1_hit | rpb_hit | mshr_hit;
	endfunction

	// where a set of read misses parks the fsm
	function automatic ctrl_state_t stall_for(input port_vec_t misses);
		if (&misses)
			return prep_stall_p01;
		if (misses[0])
			return stall_p0;
		if (misses[1])
			return stall_p1;
		return standby;
	endfunction

	task automatic check_val(input string name, input logic [3:0] got, input logic [3:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR %s: expected %h, got %h at %0t", name, exp, got, $time);
		end
	endtask

	// expected outputs from the model state and this cycle's inputs
	task automatic check_outputs();
		port_vec_t hit;
		port_vec_t stalled;
		port_vec_t addr_ports;
		port_vec_t resp;
		port_vec_t wr_slot;
		way_vec_t whw;
		way_vec_t ld;
		way_vec_t valid;
		way_vec_t din;
		logic fw;
		logic served;
		logic e_pread;
		logic e_pwrite;
		logic e_upd;
		logic e_lru_in;
		logic e_addr;
		logic e_word;
		logic e_line;
		logic e_inc_m;
		logic e_rpb_line;
		logic e_rpb_word;
		logic e_inc_r;
		hit = port_hits();
		// write slot goes to port 0 when it writes
		fw = !d_mem_write[0];
		wr_slot = fw ? 2'b10 : 2'b01;
		whw = d_mem_write[fw] ? {data1_hit[fw], data0_hit[fw]} : 2'b00;
		{stalled, addr_ports, resp, ld, valid, din} = '0;
		{e_pread, e_pwrite, e_upd, e_lru_in, e_addr, e_word} = '0;
		{e_line, e_inc_m, e_rpb_line, e_rpb_word, e_inc_r} = '0;
		case (m_state)
			data_move: begin
				if (m_prev == RW_READ) begin
					// fill into the lru way
					resp = mshr_reading_tag;
					ld = lru_out ? 2'b10 : 2'b01;
					valid = ld;
					din = mshr_dirty ? ld : 2'b00;
					e_upd = 1'b1;
					e_lru_in = !lru_out;
					e_inc_m = 1'b1;
					e_rpb_line = lru_out ? dirty1_out : dirty0_out;
				end else begin
					e_inc_r = 1'b1;
				end
			end
			protocol_fault: ;
			default: begin
				case (m_state)
					standby: addr_ports = 2'b11;
					stall_p0: begin
						stalled = 2'b01;
						addr_ports = 2'b10;
					end
					stall_p1: begin
						stalled = 2'b10;
						addr_ports = 2'b01;
					end
					prep_stall_p01: begin
						stalled = 2'b11;
						addr_ports = 2'b11;
					end
					stall_p01: stalled = 2'b11;
					// port 0 of a double write was served last cycle
					default: stalled = 2'b01;
				endcase
				e_pread = (m_rw == RW_READ) && mshr_wait;
				e_pwrite = (m_rw == RW_WRITE) && rpb_wait;
				e_line = pmem_resp && (m_rw == RW_READ);
				// no port answers while a line comes in
				if (!e_line)
					resp = ((d_mem_read & hit) | (d_mem_write & wr_slot)) & ~stalled;
				served = resp[fw] && d_mem_write[fw];
				ld = served ? whw : 2'b00;
				din = ld;
				e_upd = |ld;
				e_lru_in = served && whw[0];
				e_rpb_word = served && rpb_hit[fw];
				e_word = served && !hit[fw];
				e_addr = |(d_mem_read & ~hit & addr_ports);
			end
		endcase
		check_val("d_mem_resp", 4'(d_mem_resp), 4'(resp));
		check_val("pmem_read", 4'(pmem_read), 4'(e_pread));
		check_val("pmem_write", 4'(pmem_write), 4'(e_pwrite));
		check_val("load_data", 4'(load_data), 4'(ld));
		check_val("load_dirty", 4'(load_dirty), 4'(ld));
		check_val("load_valid", 4'(load_valid), 4'(valid));
		check_val("dirty_in", 4'(dirty_in), 4'(din));
		check_val("update_lru", 4'(update_lru), 4'(e_upd));
		check_val("lru_in", 4'(lru_in), 4'(e_lru_in));
		check_val("mshr_load_addr", 4'(mshr_load_addr), 4'(e_addr));
		check_val("mshr_load_word", 4'(mshr_load_word), 4'(e_word));
		check_val("mshr_load_line", 4'(mshr_load_line), 4'(e_line));
		check_val("inc_mshr_ptr", 4'(inc_mshr_ptr), 4'(e_inc_m));
		check_val("rpb_load_line", 4'(rpb_load_line), 4'(e_rpb_line));
		check_val("rpb_load_word", 4'(rpb_load_word), 4'(e_rpb_word));
		check_val("inc_rpb_ptr", 4'(inc_rpb_ptr), 4'(e_inc_r));
		check_val("fault", 4'(fault), 4'(m_state == protocol_fault));
	endtask

	// next state and arbiter direction at the clock edge
	task automatic model_step();
		port_vec_t rmiss;
		rmiss = d_mem_read & ~port_hits();
		case (m_state)
			standby: begin
				if (pmem_resp)
					m_state = data_move;
				else if (|(d_mem_read & d_mem_write))
					m_state = protocol_fault;
				else if (|rmiss)
					m_state = stall_for(rmiss);
				else if (&d_mem_write)
					m_state = double_write;
			end
			stall_p0,
			stall_p1: begin
				if (pmem_resp)
					m_state = data_move;
				else if (m_state == stall_p0 ? rmiss[1] : rmiss[0])
					m_state = stall_p01;
			end
			prep_stall_p01: m_state = pmem_resp ? data_move : stall_p01;
			double_write: m_state = pmem_resp ? data_move : standby;
			stall_p01: begin
				if (pmem_resp)
					m_state = data_move;
			end
			data_move: m_state = stall_for(rmiss);
			default: m_state = protocol_fault;
		endcase
		if (pmem_resp) begin
			m_prev = m_rw;
			m_rw = (m_rw == RW_READ && rpb_wait) ? RW_WRITE : RW_READ;
		end else if (m_rw == RW_READ && !mshr_wait && rpb_wait) begin
			m_rw = RW_WRITE;
		end else if (m_rw == RW_WRITE && !rpb_wait && mshr_wait) begin
			m_rw = RW_READ;
		end
	endtask

	task automatic drive_inputs(input int cyc);
		logic [3:0] h;
		// memory answers a seen request after 0 to 3 cycles
		pmem_resp = 1'b0;
		if (mem_seen) begin
			if (mem_cnt == 4'd0) begin
				pmem_resp = 1'b1;
				mem_cnt = rand_bits(2);
			end else begin
				mem_cnt = mem_cnt - 4'd1;
			end
		end
		// wait levels change slowly
		if (rand_bits(3) == 4'd0)
			mshr_wait = !mshr_wait;
		if (rand_bits(3) == 4'd0)
			rpb_wait = !rpb_wait;
		lru_out = lfsr_bit();
		dirty0_out = lfsr_bit();
		dirty1_out = lfsr_bit();
		mshr_dirty = lfsr_bit();
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (answered[p]) begin
				// answered port drops its request and idles one cycle
				d_mem_read[p] = 1'b0;
				d_mem_write[p] = 1'b0;
				pend[p] = 1'b0;
			end else if (!pend[p] && lfsr_bit()) begin
				pend[p] = 1'b1;
				d_mem_write[p] = lfsr_bit();
				d_mem_read[p] = !d_mem_write[p];
				// rare read plus write on one port
				if (cyc > FAULT_PHASE && rand_bits(3) == 4'd0) begin
					d_mem_read[p] = 1'b1;
					d_mem_write[p] = 1'b1;
				end
			end
			// one hit source per port and a miss one time in four
			h = rand_bits(2);
			data0_hit[p] = (h == 4'd1);
			data1_hit[p] = (h == 4'd2);
			rpb_hit[p] = (h == 4'd3) && lfsr_bit();
			mshr_hit[p] = (h == 4'd3) && !rpb_hit[p];
			mshr_reading_tag[p] = d_mem_read[p] && lfsr_bit();
		end
	endtask

	initial begin
		rst_n = 1'b0;
		{d_mem_read, d_mem_write, data0_hit, data1_hit} = '0;
		{rpb_hit, mshr_hit, mshr_reading_tag} = '0;
		{dirty0_out, dirty1_out, lru_out, mshr_dirty} = '0;
		{mshr_wait, rpb_wait, pmem_resp} = '0;
		lfsr = 16'd76;
		m_state = standby;
		m_rw = RW_READ;
		m_prev = RW_READ;
		pend = '0;
		answered = '0;
		mem_cnt = '0;
		mem_seen = 1'b0;
		errors = 0;
		checks = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
			drive_inputs(cyc);
			// combinational outputs settle well before the rising edge
			#(SETTLE_NS);
			check_outputs();
			mem_seen = pmem_read | pmem_write;
			answered = d_mem_resp & pend;
			@(posedge clk);
			model_step();
			@(negedge clk);
		end
		$display("%0d checks, %0d model errors, %0d assertion failures",
			checks, errors, DUT.u_sva.fail_count);
		if (errors == 0 && DUT.u_sva.fail_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, stimulus did not finish", WATCHDOG_NS);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- dcache_ctrl_assertions.sv
`timescale 1ns/1ps

module dcache_ctrl_assertions (
	input logic clk,
	input logic rst_n,
	input logic pmem_read,
	input logic pmem_write,
	input logic fault,
	input dcache_ctrl_pkg::way_vec_t load_valid,
	input dcache_ctrl_pkg::ctrl_state_t state,
	input logic prev_rw
);
	import dcache_ctrl_pkg::*;

	// failed assertions so far
	int fail_count = 0;

	// memory serves one direction at a time
	no_dual_pmem: assert property (@(posedge clk) disable iff (!rst_n)
		!(pmem_read && pmem_write))
		else begin
			$error("pmem_read and pmem_write are high in the same cycle");
			fail_count++;
		end

	// protocol fault is sticky
	fault_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		fault |=> fault)
		else begin
			$error("fault dropped before reset");
			fail_count++;
		end

	// valid bits only change when a read fill lands
	valid_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
		(|load_valid) |-> (state == data_move && prev_rw == RW_READ))
		else begin
			$error("load_valid raised outside a fill");
			fail_count++;
		end

endmodule

bind dcache_ctrl dcache_ctrl_assertions u_sva (
	.clk(clk),
	.rst_n(rst_n),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.fault(fault),
	.load_valid(load_valid),
	.state(state),
	.prev_rw(prev_rw)
);

//--- dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
	input logic clk,
	input logic rst_n,
	input dcache_ctrl_pkg::port_vec_t d_mem_read,
	input dcache_ctrl_pkg::port_vec_t d_mem_write,
	output dcache_ctrl_pkg::port_vec_t d_mem_resp,
	input dcache_ctrl_pkg::port_vec_t data0_hit,
	input dcache_ctrl_pkg::port_vec_t data1_hit,
	input dcache_ctrl_pkg::port_vec_t rpb_hit,
	input dcache_ctrl_pkg::port_vec_t mshr_hit,
	input dcache_ctrl_pkg::port_vec_t mshr_reading_tag,
	input logic dirty0_out,
	input logic dirty1_out,
	input logic lru_out,
	input logic mshr_dirty,
	input logic mshr_wait,
	input logic rpb_wait,
	output logic pmem_read,
	output logic pmem_write,
	input logic pmem_resp,
	output dcache_ctrl_pkg::way_vec_t load_data,
	output dcache_ctrl_pkg::way_vec_t load_dirty,
	output dcache_ctrl_pkg::way_vec_t load_valid,
	output dcache_ctrl_pkg::way_vec_t dirty_in,
	output logic update_lru,
	output logic lru_in,
	output logic mshr_load_addr,
	output logic mshr_load_word,
	output logic mshr_load_line,
	output logic inc_mshr_ptr,
	output logic rpb_load_line,
	output logic rpb_load_word,
	output logic inc_rpb_ptr,
	output logic fault
);
	import dcache_ctrl_pkg::*;

	port_vec_t hit_port;
	port_vec_t read_miss;
	port_vec_t write_miss;
	logic first_write;
	way_vec_t write_hit_way;
	logic illegal_req;
	logic rw_sel;
	logic prev_rw;
	ctrl_state_t state;

	// per-port hit and miss levels
	port_hit_decode u_hit (
		.d_mem_read(d_mem_read),
		.d_mem_write(d_mem_write),
		.data0_hit(data0_hit),
		.data1_hit(data1_hit),
		.rpb_hit(rpb_hit),
		.mshr_hit(mshr_hit),
		.hit_port(hit_port),
		.read_miss(read_miss),
		.write_miss(write_miss),
		.first_write(first_write),
		.write_hit_way(write_hit_way),
		.illegal_req(illegal_req)
	);

	// memory direction, fill vs write-back
	pmem_arbiter u_arb (
		.clk(clk),
		.rst_n(rst_n),
		.pmem_resp(pmem_resp),
		.mshr_wait(mshr_wait),
		.rpb_wait(rpb_wait),
		.rw_sel(rw_sel),
		.prev_rw(prev_rw)
	);

	miss_fsm u_fsm (
		.clk(clk),
		.rst_n(rst_n),
		.d_mem_read(d_mem_read),
		.d_mem_write(d_mem_write),
		.hit_port(hit_port),
		.read_miss(read_miss),
		.illegal_req(illegal_req),
		.pmem_resp(pmem_resp),
		.state(state)
	);

	// responses and datapath strobes
	ctrl_output_decode u_dec (
		.state(state),
		.d_mem_read(d_mem_read),
		.d_mem_write(d_mem_write),
		.hit_port(hit_port),
		.read_miss(read_miss),
		.write_miss(write_miss),
		.first_write(first_write),
		.write_hit_way(write_hit_way),
		.rpb_hit(rpb_hit),
		.mshr_reading_tag(mshr_reading_tag),
		.rw_sel(rw_sel),
		.prev_rw(prev_rw),
		.lru_out(lru_out),
		.dirty0_out(dirty0_out),
		.dirty1_out(dirty1_out),
		.mshr_dirty(mshr_dirty),
		.mshr_wait(mshr_wait),
		.rpb_wait(rpb_wait),
		.pmem_resp(pmem_resp),
		.d_mem_resp(d_mem_resp),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.load_data(load_data),
		.load_dirty(load_dirty),
		.load_valid(load_valid),
		.dirty_in(dirty_in),
		.update_lru(update_lru),
		.lru_in(lru_in),
		.mshr_load_addr(mshr_load_addr),
		.mshr_load_word(mshr_load_word),
		.mshr_load_line(mshr_load_line),
		.inc_mshr_ptr(inc_mshr_ptr),
		.rpb_load_line(rpb_load_line),
		.rpb_load_word(rpb_load_word),
		.inc_rpb_ptr(inc_rpb_ptr),
		.fault(fault)
	);

endmodule

//--- ctrl_output_decode.sv
`timescale 1ns/1ps

module ctrl_output_decode (
	input dcache_ctrl_pkg::ctrl_state_t state,
	input dcache_ctrl_pkg::port_vec_t d_mem_read,
	input dcache_ctrl_pkg::port_vec_t d_mem_write,
	input dcache_ctrl_pkg::port_vec_t hit_port,
	input dcache_ctrl_pkg::port_vec_t read_miss,
	input dcache_ctrl_pkg::port_vec_t write_miss,
	input logic first_write,
	input dcache_ctrl_pkg::way_vec_t write_hit_way,
	input dcache_ctrl_pkg::port_vec_t rpb_hit,
	input dcache_ctrl_pkg::port_vec_t mshr_reading_tag,
	input logic rw_sel,
	input logic prev_rw,
	input logic lru_out,
	input logic dirty0_out,
	input logic dirty1_out,
	input logic mshr_dirty,
	input logic mshr_wait,
	input logic rpb_wait,
	input logic pmem_resp,
	output dcache_ctrl_pkg::port_vec_t d_mem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output dcache_ctrl_pkg::way_vec_t load_data,
	output dcache_ctrl_pkg::way_vec_t load_dirty,
	output dcache_ctrl_pkg::way_vec_t load_valid,
	output dcache_ctrl_pkg::way_vec_t dirty_in,
	output logic update_lru,
	output logic lru_in,
	output logic mshr_load_addr,
	output logic mshr_load_word,
	output logic mshr_load_line,
	output logic inc_mshr_ptr,
	output logic rpb_load_line,
	output logic rpb_load_word,
	output logic inc_rpb_ptr,
	output logic fault
);
	import dcache_ctrl_pkg::*;

	logic mem_read_resp;
	logic fill;
	logic served_write;
	port_vec_t stalled;
	port_vec_t addr_ports;
	port_vec_t rd_ok;
	port_vec_t wr_ok;

	// a line is coming back from memory into the mshr
	assign mem_read_resp = pmem_resp & (rw_sel == RW_READ);
	// data_move after a read moves the mshr line into the cache
	assign fill = (prev_rw == RW_READ);
	assign fault = (state == protocol_fault);

	// hit reads can always be answered
	assign rd_ok = d_mem_read & hit_port;

	// a write is answered only from the write slot
	always_comb begin
		for (int p = 0; p < NUM_PORTS; p++)
			wr_ok[p] = d_mem_write[p] & (int'(first_write) == p);
	end

	// which ports are blocked, and which may push a miss address
	always_comb begin
		stalled = '0;
		addr_ports = '0;
		case (state)
			standby: addr_ports = '1;
			stall_p0: begin
				stalled[0] = 1'b1;
				addr_ports[1] = 1'b1;
			end
			stall_p1: begin
				stalled[1] = 1'b1;
				addr_ports[0] = 1'b1;
			end
			// second address of a double miss goes in here
			prep_stall_p01: begin
				stalled = '1;
				addr_ports = '1;
			end
			stall_p01: stalled = '1;
			// port 0 already went out in the cycle before
			double_write: stalled[0] = 1'b1;
			default: stalled = '1;
		endcase
	end

	always_comb begin
		d_mem_resp = '0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		load_data = '0;
		load_dirty = '0;
		load_valid = '0;
		dirty_in = '0;
		update_lru = 1'b0;
		lru_in = 1'b0;
		mshr_load_addr = 1'b0;
		mshr_load_word = 1'b0;
		mshr_load_line = 1'b0;
		inc_mshr_ptr = 1'b0;
		rpb_load_line = 1'b0;
		rpb_load_word = 1'b0;
		inc_rpb_ptr = 1'b0;
		served_write = 1'b0;
		case (state)
			data_move: begin
				if (fill) begin
					d_mem_resp = mshr_reading_tag;
					// returned line replaces the lru way
					load_data[lru_out] = 1'b1;
					load_valid[lru_out] = 1'b1;
					load_dirty[lru_out] = 1'b1;
					dirty_in[lru_out] = mshr_dirty;
					update_lru = 1'b1;
					lru_in = ~lru_out;
					inc_mshr_ptr = 1'b1;
					// dirty victim is pushed into the write-back buffer
					rpb_load_line = lru_out ? dirty1_out : dirty0_out;
				end else begin
					// write-back finished, retire the rpb entry
					inc_rpb_ptr = 1'b1;
				end
			end
			// all outputs low except fault
			protocol_fault: ;
			default: begin
				pmem_read = (rw_sel == RW_READ) & mshr_wait;
				pmem_write = (rw_sel == RW_WRITE) & rpb_wait;
				mshr_load_line = mem_read_resp;
				// ports wait while the mshr takes a line
				if (!mem_read_resp)
					d_mem_resp = (rd_ok | wr_ok) & ~stalled;
				served_write = d_mem_resp[first_write] & d_mem_write[first_write];
				// write hit goes straight into its way and marks it dirty
				load_data = write_hit_way & {NUM_WAYS{served_write}};
				load_dirty = load_data;
				dirty_in = load_data;
				update_lru = |load_data;
				// the other way becomes least recently used
				lru_in = write_hit_way[0] & served_write;
				rpb_load_word = served_write & rpb_hit[first_write];
				mshr_load_word = served_write & write_miss[first_write];
				mshr_load_addr = |(read_miss & addr_ports);
			end
		endcase
	end

endmodule

//--- miss_fsm.sv
`timescale 1ns/1ps

module miss_fsm (
	input logic clk,
	input logic rst_n,
	input dcache_ctrl_pkg::port_vec_t d_mem_read,
	input dcache_ctrl_pkg::port_vec_t d_mem_write,
	input dcache_ctrl_pkg::port_vec_t hit_port,
	input dcache_ctrl_pkg::port_vec_t read_miss,
	input logic illegal_req,
	input logic pmem_resp,
	output dcache_ctrl_pkg::ctrl_state_t state
);
	import dcache_ctrl_pkg::*;

	ctrl_state_t next_state;
	port_vec_t pending_rd;

	// stall state for a set of read-missing ports
	// a double miss needs one extra cycle to load the second mshr address
	function automatic ctrl_state_t miss_target(port_vec_t misses);
		case (misses)
			2'b11: return prep_stall_p01;
			2'b01: return stall_p0;
			2'b10: return stall_p1;
			default: return standby;
		endcase
	endfunction

	// reads still open after the fill
	// the port being filled sees its line through mshr_hit this cycle
	assign pending_rd = d_mem_read & ~hit_port;

	always_comb begin
		next_state = state;
		case (state)
			standby: begin
				if (pmem_resp)
					next_state = data_move;
				else if (illegal_req)
					next_state = protocol_fault;
				else if (|read_miss)
					next_state = miss_target(read_miss);
				else if (&d_mem_write)
					next_state = double_write;
			end
			stall_p0: begin
				if (pmem_resp)
					next_state = data_move;
				else if (read_miss[1])
					next_state = stall_p01;
			end
			stall_p1: begin
				if (pmem_resp)
					next_state = data_move;
				else if (read_miss[0])
					next_state = stall_p01;
			end
			prep_stall_p01: begin
				if (pmem_resp)
					next_state = data_move;
				else
					next_state = stall_p01;
			end
			stall_p01: begin
				if (pmem_resp)
					next_state = data_move;
			end
			double_write: begin
				// a fill arriving here must still reach data_move
				if (pmem_resp)
					next_state = data_move;
				else
					next_state = standby;
			end
			// one cycle, then whatever read misses are left
			data_move: next_state = miss_target(pending_rd);
			// sticky until reset
			protocol_fault: next_state = protocol_fault;
			default: next_state = standby;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= standby;
		else
			state <= next_state;
	end

endmodule

//--- pmem_arbiter.sv
`timescale 1ns/1ps

module pmem_arbiter (
	input logic clk,
	input logic rst_n,
	input logic pmem_resp,
	input logic mshr_wait,
	input logic rpb_wait,
	output logic rw_sel,
	output logic prev_rw
);
	import dcache_ctrl_pkg::*;

	// rw_sel is the direction memory is working on now
	// prev_rw is the direction of the transfer that finished last
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rw_sel <= RW_READ;
			prev_rw <= RW_READ;
		end else if (pmem_resp) begin
			prev_rw <= rw_sel;
			// after a fill give a pending write-back its turn, else back to reads
			if (rw_sel == RW_READ && rpb_wait)
				rw_sel <= RW_WRITE;
			else
				rw_sel <= RW_READ;
		end else if (rw_sel == RW_READ && !mshr_wait && rpb_wait) begin
			// idle read side, switch to the waiting write-back
			rw_sel <= RW_WRITE;
		end else if (rw_sel == RW_WRITE && !rpb_wait && mshr_wait) begin
			rw_sel <= RW_READ;
		end
	end

endmodule

//--- port_hit_decode.sv
`timescale 1ns/1ps

module port_hit_decode (
	input dcache_ctrl_pkg::port_vec_t d_mem_read,
	input dcache_ctrl_pkg::port_vec_t d_mem_write,
	input dcache_ctrl_pkg::port_vec_t data0_hit,
	input dcache_ctrl_pkg::port_vec_t data1_hit,
	input dcache_ctrl_pkg::port_vec_t rpb_hit,
	input dcache_ctrl_pkg::port_vec_t mshr_hit,
	output dcache_ctrl_pkg::port_vec_t hit_port,
	output dcache_ctrl_pkg::port_vec_t read_miss,
	output dcache_ctrl_pkg::port_vec_t write_miss,
	output logic first_write,
	output dcache_ctrl_pkg::way_vec_t write_hit_way,
	output logic illegal_req
);
	import dcache_ctrl_pkg::*;

	// a port hits if its line sits in either way, the rpb or the mshr
	assign hit_port = data0_hit | data1_hit | rpb_hit | mshr_hit;

	// read miss stalls the port, write miss only parks a word in the mshr
	assign read_miss = d_mem_read & ~hit_port;
	assign write_miss = d_mem_write & ~hit_port;

	// single write slot per cycle
	// port 0 owns it whenever it writes, port 1 gets it otherwise
	assign first_write = !d_mem_write[0];

	// way hit by the write in the slot
	// zero when that port is not writing or hits only rpb/mshr
	assign write_hit_way = {data1_hit[first_write], data0_hit[first_write]}
		& {NUM_WAYS{d_mem_write[first_write]}};

	// read and write on the same port in one cycle cannot be served
	assign illegal_req = |(d_mem_read & d_mem_write);

endmodule

//--- dcache_ctrl_pkg.sv
package dcache_ctrl_pkg;

	// cache port count, fixed by the state set
	localparam int NUM_PORTS = 2;
	// associativity
	localparam int NUM_WAYS = 2;

	// one bit per cache port, bit 0 is port 0
	typedef logic [NUM_PORTS-1:0] port_vec_t;
	// one bit per way, bit 0 is way 0
	typedef logic [NUM_WAYS-1:0] way_vec_t;

	// arbiter direction bit
	localparam logic RW_READ = 1'b1;
	localparam logic RW_WRITE = 1'b0;

	// miss handling states
	typedef enum logic [2:0] {
		standby,
		stall_p0,
		stall_p1,
		prep_stall_p01,
		stall_p01,
		double_write,
		data_move,
		protocol_fault
	} ctrl_state_t;

endpackage
